// ==== files.f ====
rtl/silver_isa_pkg.sv
rtl/silver_pipe_pkg.sv
rtl/reg_file.sv
rtl/alu_shift.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/silver_core.sv
test/silver_core_tb.sv

// ==== rtl/alu_shift.sv ====
`timescale 1ns/1ns

module alu_shift (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      enable,
   input  silver_isa_pkg::alu_func_t func,
   input  silver_isa_pkg::word_t     a,
   input  silver_isa_pkg::word_t     b,
   input  silver_isa_pkg::word_t     shift_a,
   input  silver_isa_pkg::word_t     shift_b,
   output silver_isa_pkg::word_t     alu_res,
   output silver_isa_pkg::word_t     shift_res
);
   import silver_isa_pkg::*;

   logic        carry_flag;
   logic        overflow_flag;
   logic [32:0] sum;
   word_t       diff;
   logic [63:0] prod;
   logic [63:0] rot;
   logic        add_ovf;
   logic        sub_ovf;

   assign sum     = {1'b0, a} + {1'b0, b} + {32'b0, carry_flag && func == fn_add_with_carry};
   assign diff    = a - b;
   assign prod    = {32'b0, a} * {32'b0, b};
   assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
   assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);
   assign rot     = {shift_a, shift_a} >> shift_b[4:0];  // rotate by bV mod 32

   always_comb begin
      case (func)
         fn_add, fn_add_with_carry: alu_res = sum[31:0];
         fn_sub:      alu_res = diff;
         fn_carry:    alu_res = {31'b0, carry_flag};
         fn_overflow: alu_res = {31'b0, overflow_flag};
         fn_inc:      alu_res = a + 32'd1;
         fn_dec:      alu_res = a - 32'd1;
         fn_mul:      alu_res = prod[31:0];
         fn_mul_hu:   alu_res = prod[63:32];
         fn_and:      alu_res = a & b;
         fn_or:       alu_res = a | b;
         fn_xor:      alu_res = a ^ b;
         fn_equal:    alu_res = {31'b0, a == b};
         fn_less:     alu_res = {31'b0, $signed(a) < $signed(b)};
         fn_lower:    alu_res = {31'b0, a < b};
         default:     alu_res = b;  // snd
      endcase
   end

   always_comb begin
      case (func[1:0])
         2'd0:    shift_res = shift_a << shift_b;
         2'd1:    shift_res = shift_a >> shift_b;
         2'd2:    shift_res = word_t'($signed(shift_a) >>> shift_b);
         default: shift_res = rot[31:0];
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         carry_flag    <= 1'b0;
         overflow_flag <= 1'b0;
      end else if (enable) begin
         case (func)
            fn_add: begin
               carry_flag    <= sum[32];
               overflow_flag <= add_ovf;
            end
            fn_add_with_carry: carry_flag <= sum[32];
            fn_sub:            overflow_flag <= sub_ovf;
            default: ;
         endcase
      end
   end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
   input  logic                       clk,
   input  logic                       rst,
   input  silver_pipe_pkg::if_id_t    if_id,
   input  silver_pipe_pkg::redirect_t redirect,
   output silver_isa_pkg::reg_addr_t  addr_a,
   output silver_isa_pkg::reg_addr_t  addr_b,
   output silver_isa_pkg::reg_addr_t  addr_w,
   input  silver_isa_pkg::word_t      data_a,
   input  silver_isa_pkg::word_t      data_b,
   input  silver_isa_pkg::word_t      data_w,
   output silver_pipe_pkg::id_ex_t    id_ex
);
   import silver_isa_pkg::*;
   import silver_pipe_pkg::*;

   instr_t  ins;
   word_t   iw;
   opcode_t opc;
   logic    use_a;
   logic    use_b;
   logic    use_w;
   id_ex_t  nxt;

   function automatic word_t sext6(input reg_addr_t f);
      return {{26{f[5]}}, f};
   endfunction

   assign ins    = if_id.instr;
   assign iw     = if_id.instr;
   assign addr_a = ins.ra;
   assign addr_b = ins.rb;
   assign addr_w = ins.rw;

   always_comb begin
      opc = op_invalid;
      if (ins.con) begin
         if (ins.rw_imm) begin
            opc = op_load_constant;
         end else if (iw[23:9] == '0) begin
            opc = op_load_upper_constant;
         end
      end else if (ins.opcode inside {op_jump_if_zero, op_jump_if_not_zero}) begin
         opc = opcode_t'(ins.opcode);  // immediate wV allowed here
      end else if (!ins.rw_imm && ins.opcode inside {op_normal, op_shift, op_out, op_in, op_jump}) begin
         opc = opcode_t'(ins.opcode);
      end
   end

   assign use_a = !(opc inside {op_in, op_load_constant, op_load_upper_constant, op_invalid});
   assign use_b = opc inside {op_normal, op_shift, op_out, op_jump_if_zero, op_jump_if_not_zero};
   assign use_w = opc inside {op_jump_if_zero, op_jump_if_not_zero, op_load_upper_constant};

   always_comb begin
      nxt.valid  = if_id.valid && opc != op_invalid && !redirect.take;
      nxt.pc     = if_id.pc;
      nxt.opcode = opc;
      if (opc inside {op_normal, op_shift, op_out, op_jump, op_jump_if_zero,
                      op_jump_if_not_zero}) begin
         nxt.func = alu_func_t'(ins.func);
      end else begin
         nxt.func = fn_and;
      end
      nxt.a_val = ins.ra_imm ? sext6(ins.ra) : data_a;
      nxt.b_val = ins.rb_imm ? sext6(ins.rb) : data_b;
      nxt.w_val = ins.rw_imm ? sext6(ins.rw) : data_w;
      nxt.ra    = ins.ra;
      nxt.rb    = ins.rb;
      nxt.rw    = ins.rw;
      nxt.a_reg = use_a && !ins.ra_imm;
      nxt.b_reg = use_b && !ins.rb_imm;
      nxt.w_reg = use_w && !ins.rw_imm;
      case (opc)
         op_load_constant:       nxt.konst = iw[23] ? -word_t'(iw[22:0]) : word_t'(iw[22:0]);
         op_load_upper_constant: nxt.konst = word_t'(iw[8:0]);  // merged in execute
         default:                nxt.konst = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      id_ex <= nxt;
      if (rst) begin
         id_ex.valid <= 1'b0;
      end
   end

   a_no_valid_invalid: assert property (@(posedge clk) disable iff (rst)
      id_ex.valid |-> id_ex.opcode != op_invalid);

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
   input  logic                       clk,
   input  logic                       rst,
   input  silver_pipe_pkg::id_ex_t    id_ex,
   input  silver_pipe_pkg::mem_wb_t   mem_wb,
   input  silver_isa_pkg::in_word_t   data_in,
   output silver_pipe_pkg::redirect_t redirect,
   output silver_pipe_pkg::ex_mem_t   ex_mem
);
   import silver_isa_pkg::*;
   import silver_pipe_pkg::*;

   word_t    a_val;
   word_t    b_val;
   word_t    w_val;
   word_t    alu_a;
   word_t    alu_b;
   word_t    alu_res;
   word_t    shift_res;
   word_t    pc_plus4;
   npc_sel_t npc_sel;
   ex_mem_t  nxt;

   // the youngest producer wins
   function automatic word_t fwd_val(input logic from_reg, input reg_addr_t r, input word_t dec,
                                     input ex_mem_t em, input mem_wb_t mw);
      fwd_sel_t sel;
      sel = fwd_none;
      if (from_reg && mw.valid && mw.wr_en && mw.rw == r) begin
         sel = fwd_wb;
      end
      if (from_reg && em.valid && em.wr_en && em.rw == r) begin
         sel = fwd_mem;
      end
      case (sel)
         fwd_mem: return em.result;
         fwd_wb:  return mw.result;
         default: return dec;
      endcase
   endfunction

   always_comb begin
      a_val = fwd_val(id_ex.a_reg, id_ex.ra, id_ex.a_val, ex_mem, mem_wb);
      b_val = fwd_val(id_ex.b_reg, id_ex.rb, id_ex.b_val, ex_mem, mem_wb);
      w_val = fwd_val(id_ex.w_reg, id_ex.rw, id_ex.w_val, ex_mem, mem_wb);
   end

   assign pc_plus4 = id_ex.pc + 32'd4;
   assign alu_a    = (id_ex.opcode == op_jump) ? id_ex.pc : a_val;
   assign alu_b    = (id_ex.opcode == op_jump) ? a_val : b_val;

   alu_shift u_alu (
      .clk(clk), .rst(rst), .enable(id_ex.valid), .func(id_ex.func),
      .a(alu_a), .b(alu_b), .shift_a(a_val), .shift_b(b_val),
      .alu_res(alu_res), .shift_res(shift_res)
   );

   always_comb begin
      npc_sel = npc_step;
      if (id_ex.valid) begin
         case (id_ex.opcode)
            op_jump:             npc_sel = npc_alu;
            op_jump_if_zero:     npc_sel = (alu_res == '0) ? npc_rel : npc_step;
            op_jump_if_not_zero: npc_sel = (alu_res != '0) ? npc_rel : npc_step;
            default: ;
         endcase
      end
      redirect.take   = npc_sel != npc_step;
      redirect.target = (npc_sel == npc_alu) ? alu_res : id_ex.pc + w_val;
   end

   always_comb begin
      nxt.valid  = id_ex.valid;
      nxt.opcode = id_ex.opcode;
      nxt.rw     = id_ex.rw;
      nxt.wr_en  = !(id_ex.opcode inside {op_jump_if_zero, op_jump_if_not_zero, op_invalid});
      case (id_ex.opcode)
         op_shift:               nxt.result = shift_res;
         op_in:                  nxt.result = word_t'(data_in);
         op_jump:                nxt.result = pc_plus4;  // link
         op_load_constant:       nxt.result = id_ex.konst;
         op_load_upper_constant: nxt.result = {id_ex.konst[8:0], w_val[22:0]};
         default:                nxt.result = alu_res;
      endcase
   end

   always_ff @(posedge clk) begin
      ex_mem <= nxt;
      if (rst) begin
         ex_mem.valid <= 1'b0;
      end
   end

   a_redirect_jump: assert property (@(posedge clk) disable iff (rst)
      redirect.take |-> id_ex.valid &&
         id_ex.opcode inside {op_jump, op_jump_if_zero, op_jump_if_not_zero});

endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage #(
   parameter silver_isa_pkg::word_t reset_pc = '0
) (
   input  logic                       clk,
   input  logic                       rst,
   input  silver_pipe_pkg::redirect_t redirect,
   input  silver_isa_pkg::word_t      inst_rdata,
   output silver_isa_pkg::word_t      pc,
   output silver_pipe_pkg::if_id_t    if_id
);
   import silver_isa_pkg::*;
   import silver_pipe_pkg::*;

   word_t  pc_next;
   if_id_t fetched;

   assign pc_next = redirect.take ? redirect.target : pc + 32'd4;

   always_comb begin
      fetched.valid = !redirect.take;
      fetched.pc    = pc;
      // squashed slot carries an invalid word
      if (redirect.take) begin
         fetched.instr = instr_t'(instr_invalid);
      end else begin
         fetched.instr = instr_t'(inst_rdata);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= reset_pc;
      end else begin
         pc <= pc_next;
      end
   end

   always_ff @(posedge clk) begin
      if_id <= fetched;
      if (rst) begin
         if_id.valid <= 1'b0;
      end
   end

   a_fetch_squash: assert property (@(posedge clk) disable iff (rst)
      redirect.take |=> !if_id.valid);

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
   input  logic                        clk,
   input  logic                        rst,
   input  silver_isa_pkg::reg_addr_t   addr_a,
   input  silver_isa_pkg::reg_addr_t   addr_b,
   input  silver_isa_pkg::reg_addr_t   addr_w,
   output silver_isa_pkg::word_t       data_a,
   output silver_isa_pkg::word_t       data_b,
   output silver_isa_pkg::word_t       data_w,
   input  silver_pipe_pkg::reg_write_t wr
);
   import silver_isa_pkg::*;

   word_t regs [0:63];

   always_ff @(posedge clk) begin
      if (rst) begin
         regs <= '{default: '0};
      end else if (wr.en) begin
         regs[wr.addr] <= wr.data;
      end
   end

   // write-through so decode sees the value landing this cycle
   assign data_a = (wr.en && wr.addr == addr_a) ? wr.data : regs[addr_a];
   assign data_b = (wr.en && wr.addr == addr_b) ? wr.data : regs[addr_b];
   assign data_w = (wr.en && wr.addr == addr_w) ? wr.data : regs[addr_w];

endmodule

// ==== rtl/silver_core.sv ====
`timescale 1ns/1ns

module silver_core #(
   parameter silver_isa_pkg::word_t reset_pc = '0
) (
   input  logic                      clk,
   input  logic                      rst,
   output silver_isa_pkg::word_t     pc,
   input  silver_isa_pkg::word_t     inst_rdata,
   input  silver_isa_pkg::in_word_t  data_in,
   output silver_isa_pkg::out_word_t data_out
);
   import silver_isa_pkg::*;
   import silver_pipe_pkg::*;

   if_id_t     if_id;
   id_ex_t     id_ex;
   ex_mem_t    ex_mem;
   mem_wb_t    mem_wb;
   reg_write_t wr;
   redirect_t  redirect;
   reg_addr_t  addr_a;
   reg_addr_t  addr_b;
   reg_addr_t  addr_w;
   word_t      data_a;
   word_t      data_b;
   word_t      data_w;

   fetch_stage #(.reset_pc(reset_pc)) u_fetch (
      .clk(clk), .rst(rst), .redirect(redirect), .inst_rdata(inst_rdata),
      .pc(pc), .if_id(if_id)
   );

   decode_stage u_decode (
      .clk(clk), .rst(rst), .if_id(if_id), .redirect(redirect),
      .addr_a(addr_a), .addr_b(addr_b), .addr_w(addr_w),
      .data_a(data_a), .data_b(data_b), .data_w(data_w), .id_ex(id_ex)
   );

   reg_file u_regs (
      .clk(clk), .rst(rst), .addr_a(addr_a), .addr_b(addr_b), .addr_w(addr_w),
      .data_a(data_a), .data_b(data_b), .data_w(data_w), .wr(wr)
   );

   execute_stage u_execute (
      .clk(clk), .rst(rst), .id_ex(id_ex), .mem_wb(mem_wb), .data_in(data_in),
      .redirect(redirect), .ex_mem(ex_mem)
   );

   writeback_stage u_writeback (
      .clk(clk), .rst(rst), .ex_mem(ex_mem), .mem_wb(mem_wb), .wr(wr),
      .data_out(data_out)
   );

endmodule

// ==== rtl/silver_isa_pkg.sv ====
package silver_isa_pkg;

   typedef logic [31:0] word_t;
   typedef logic [5:0]  reg_addr_t;
   typedef logic [3:0]  func_t;
   typedef logic [1:0]  in_word_t;
   typedef logic [9:0]  out_word_t;

   // decoded opcodes, raw field values where they exist
   typedef enum logic [5:0] {
      op_normal              = 6'd0,
      op_shift               = 6'd1,
      op_out                 = 6'd6,
      op_in                  = 6'd7,
      op_jump                = 6'd9,
      op_jump_if_zero        = 6'd10,
      op_jump_if_not_zero    = 6'd11,
      op_load_constant       = 6'd13,
      op_load_upper_constant = 6'd14,
      op_invalid             = 6'd15
   } opcode_t;

   typedef enum logic [3:0] {
      fn_add, fn_add_with_carry, fn_sub, fn_carry,
      fn_overflow, fn_inc, fn_dec, fn_mul,
      fn_mul_hu, fn_and, fn_or, fn_xor,
      fn_equal, fn_less, fn_lower, fn_snd
   } alu_func_t;

   // instruction word layout, msb first
   typedef struct packed {
      logic       rw_imm;  // bit 31
      reg_addr_t  rw;      // 30:25
      logic       con;     // constant flag at bit 24
      logic       ra_imm;  // bit 23
      reg_addr_t  ra;      // 22:17
      logic       rb_imm;  // bit 16
      reg_addr_t  rb;      // 15:10
      func_t      func;    // 9:6
      logic [5:0] opcode;  // 5:0
   } instr_t;

   // opcode field all ones
   localparam word_t instr_invalid = 32'h0000_003f;

endpackage

// ==== rtl/silver_pipe_pkg.sv ====
package silver_pipe_pkg;

   import silver_isa_pkg::*;

   typedef struct packed {
      logic   valid;
      word_t  pc;
      instr_t instr;
   } if_id_t;

   typedef struct packed {
      logic      valid;
      word_t     pc;
      opcode_t   opcode;
      alu_func_t func;
      word_t     a_val;
      word_t     b_val;
      word_t     w_val;
      reg_addr_t ra;
      reg_addr_t rb;
      reg_addr_t rw;
      logic      a_reg;   // operand came from the register file
      logic      b_reg;
      logic      w_reg;
      word_t     konst;
   } id_ex_t;

   typedef struct packed {
      logic      valid;
      opcode_t   opcode;
      reg_addr_t rw;
      logic      wr_en;
      word_t     result;
   } ex_mem_t;

   // same contents one stage later
   typedef ex_mem_t mem_wb_t;

   typedef struct packed {
      logic      en;
      reg_addr_t addr;
      word_t     data;
   } reg_write_t;

   typedef struct packed {
      logic  take;
      word_t target;
   } redirect_t;

   // operand source in execute
   typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_t;

   // where a redirect target comes from
   typedef enum logic [1:0] {npc_step, npc_alu, npc_rel} npc_sel_t;

endpackage

// ==== rtl/writeback_stage.sv ====
`timescale 1ns/1ns

module writeback_stage (
   input  logic                        clk,
   input  logic                        rst,
   input  silver_pipe_pkg::ex_mem_t    ex_mem,
   output silver_pipe_pkg::mem_wb_t    mem_wb,
   output silver_pipe_pkg::reg_write_t wr,
   output silver_isa_pkg::out_word_t   data_out
);
   import silver_isa_pkg::*;

   // memory stage register, no memory access left
   always_ff @(posedge clk) begin
      mem_wb <= ex_mem;
      if (rst) begin
         mem_wb.valid <= 1'b0;
      end
   end

   always_comb begin
      wr.en   = mem_wb.valid && mem_wb.wr_en;
      wr.addr = mem_wb.rw;
      wr.data = mem_wb.result;
   end

   // out updates as the instruction enters write-back
   always_ff @(posedge clk) begin
      if (rst) begin
         data_out <= '0;
      end else if (ex_mem.valid && ex_mem.opcode == op_out) begin
         data_out <= ex_mem.result[9:0];
      end
   end

endmodule

// ==== test/silver_core_tb.sv ====
`timescale 1ns/1ns

module silver_core_tb;
   import silver_isa_pkg::*;

   localparam int halt_cycles = 8;  // cycles spent in the halt loop window

   logic      clk;
   logic      rst;
   word_t     pc;
   word_t     inst_rdata;
   in_word_t  data_in;
   out_word_t data_out;

   word_t tdata [0:255];
   word_t prog [0:63];
   int    prog_len;
   int    cycles;
   int    limit;

   silver_core #(.reset_pc('0)) u_dut (
      .clk(clk),
      .rst(rst),
      .pc(pc),
      .inst_rdata(inst_rdata),
      .data_in(data_in),
      .data_out(data_out)
   );

   always #10 clk = ~clk;

   // instruction memory, answered in the same cycle
   always_comb begin
      if ((pc >> 2) < word_t'(prog_len)) begin
         inst_rdata = prog[pc >> 2];
      end else begin
         inst_rdata = instr_invalid;
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("timeout: the program did not reach its halt loop after %0d cycles", cycles);
         $display("SIMULATION FAILED");
         $fatal(1, "timeout");
      end
   end

   task automatic check_eq(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic run_block(input int blk, inout int p);
      int        len;
      int        n_out;
      int        loop_cnt;
      int        i;
      word_t     halt_addr;
      out_word_t last;
      out_word_t seen [$];
      @(negedge clk);
      rst     = 1'b1;
      data_in = in_word_t'(tdata[p]);
      len     = tdata[p + 1];
      for (i = 0; i < 64; i++) begin
         prog[i] = (i < len) ? tdata[p + 2 + i] : instr_invalid;
      end
      prog_len  = len;
      halt_addr = tdata[p + 2 + len];
      n_out     = tdata[p + 3 + len];
      p         = p + 4 + len;  // now at the expected outs
      repeat (4) @(negedge clk);
      check_eq(word_t'(data_out), '0, $sformatf("data_out after reset, block %0d", blk));
      check_eq(pc, '0, $sformatf("pc after reset, block %0d", blk));
      rst      = 1'b0;
      last     = '0;
      loop_cnt = 0;
      while (loop_cnt < halt_cycles) begin
         @(negedge clk);
         if (data_out !== last) begin
            seen.push_back(data_out);
            last = data_out;
         end
         if (pc >= halt_addr && pc <= halt_addr + 32'd8) begin
            loop_cnt++;
         end else begin
            loop_cnt = 0;
         end
      end
      check_eq(word_t'(seen.size()), word_t'(n_out),
               $sformatf("number of out values, block %0d", blk));
      for (i = 0; i < n_out; i++) begin
         check_eq(word_t'(seen[i]), word_t'(tdata[p + i][9:0]),
                  $sformatf("out value %0d, block %0d", i, blk));
      end
      p = p + n_out;
   endtask

   initial begin
      int n_blocks;
      int p;
      int b;
      int len;
      clk      = 1'b0;
      rst      = 1'b1;
      data_in  = '0;
      prog_len = 0;
      cycles   = 0;
      limit    = 0;
      $readmemh("test/silver_testdata.txt", tdata);
      n_blocks = tdata[0];
      // walk the blocks once for the cycle budget
      p = 1;
      for (b = 0; b < n_blocks; b++) begin
         len   = tdata[p + 1];
         limit = limit + 8 * len + 64;
         p     = p + 4 + len + tdata[p + 3 + len];
      end
      p = 1;
      for (b = 0; b < n_blocks; b++) begin
         run_block(b, p);
      end
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// ==== test/silver_testdata.txt ====
// first word: block count. per block: data_in, program length, instruction words
// from address 0, halt address, expected out count, expected out values (low 10 bits)
00000005
// constants
00000000 00000008
83000123 7E030286 85800005 7E050286 030001FF 06035C41 7E070286 00800009
0000001C 00000003
00000123 000003FB 000001FF
// alu functions and flags
00000000 0000001B
7E8B0C06 7EFF0406 7E8100C6 7E850C46 7E8100C6 7E871486 7E930146 7E930186
7E8FF5C6 7EFF0A06 7EB93A46 7EB93A86 7EB93AC6 7E8F2306 7EFB0B46 7EFB0B86
7E81E7C6 837FFFFF 030000FF 7E030406 7E810106 7E930886 7E810106 7E8117C6
7E03FC86 7E810106 00800009
00000068 00000018
00000008 00000000 00000001 00000006 00000000 000003FE 0000000A 00000008
000003EB 00000001 0000000C 0000001E 00000012 00000000 00000001 00000000
000003F9 00000000 00000001 00000007 00000000 00000005 00000000 00000001
// shifts and input
00000002 0000000C
83801234 04031001 06032041 08031081 0A03F0C1 0C000007 7E050286 7E070286
7E090286 7E0B0286 7E0D0286 00800009
0000002C 00000005
000000C0 000003ED 000002DC 000000CF 00000002
// back-to-back dependences
00000001 00000008
83000005 7E030406 04030C00 06020800 7E060AC6 7E020C06 7E050286 00800009
0000001C 00000004
00000006 00000005 00000012 00000008
// jumps, squashed outs use 1F and 1E
00000000 00000011
83000000 9803028A 7E817FC6 7E817BC6 7E810FC6 9803028B 7E8113C6 9883028A
7E8117C6 9883028B 7E817FC6 7E817BC6 04980009 7E817FC6 7E817BC6 7E050286
00800009
00000040 00000004
00000003 00000004 00000005 00000034
